//--- rtl/axil_monitor_params.svh
/*
 * AXI-lite monitor parameters
 * Bus widths, counter depth and the time limits used by the
 * stall and delay checks of the protocol monitor
 */
`ifndef AXIL_MONITOR_PARAMS_SVH
`define AXIL_MONITOR_PARAMS_SVH

// Read data width of the watched bus
`define AXIL_DATA_WIDTH 32

// Width of each outstanding transaction counter
`define AXIL_LGDEPTH 4

// Cycles a request may wait for its ready
`define AXIL_MAX_WAIT 12

// Cycles a response may be held off by the master
`define AXIL_MAX_RSTALL 12

// Cycles from request to response
`define AXIL_MAX_DELAY 24

// Timer width, must hold the largest limit above
`define AXIL_LGTIMEOUT 5

`endif

//--- rtl/axil_monitor_pkg.sv
/*
 * AXI-lite monitor package
 * Response opcodes, fault codes and monitor states shared by
 * the monitor blocks
 */
`default_nettype none

`include "axil_monitor_params.svh"

package axil_monitor_pkg;

	// AXI response opcode
	typedef enum logic [1:0] {
		RESP_OKAY   = 2'b00,
		RESP_EXOKAY = 2'b01,
		RESP_SLVERR = 2'b10,
		RESP_DECERR = 2'b11
	} axil_resp_e;

	// Fault codes, listed highest priority first
	typedef enum logic [3:0] {
		FAULT_NONE       = 4'd0,
		FAULT_OVERFLOW   = 4'd1,
		FAULT_B_NO_REQ   = 4'd2,
		FAULT_R_NO_REQ   = 4'd3,
		FAULT_B_UNSTABLE = 4'd4,
		FAULT_R_UNSTABLE = 4'd5,
		FAULT_EXOKAY     = 4'd6,
		FAULT_REQ_STALL  = 4'd7,
		FAULT_RESP_STALL = 4'd8,
		FAULT_RESP_DELAY = 4'd9
	} fault_code_e;

	// Monitor state
	typedef enum logic [1:0] {
		MON_IDLE  = 2'd0,
		MON_BUSY  = 2'd1,
		MON_FAULT = 2'd2
	} mon_state_e;

	// Outstanding transaction count
	typedef logic [`AXIL_LGDEPTH-1:0] txn_count_t;

endpackage

`default_nettype wire

//--- rtl/axil_txn_counter.sv
/*
 * AXI-lite outstanding transaction counters
 * Tracks write address, write data and read requests still
 * waiting for a response, and flags a saturated counter
 */
`timescale 1ns/1ps
`default_nettype none

module axil_txn_counter
	import axil_monitor_pkg::*;
(
	input  wire        i_clk,
	input  wire        i_axi_reset_n,
	input  wire        i_axi_awvalid,
	input  wire        i_axi_awready,
	input  wire        i_axi_wvalid,
	input  wire        i_axi_wready,
	input  wire        i_axi_bvalid,
	input  wire        i_axi_bready,
	input  wire        i_axi_arvalid,
	input  wire        i_axi_arready,
	input  wire        i_axi_rvalid,
	input  wire        i_axi_rready,
	output txn_count_t o_awr_outstanding,
	output txn_count_t o_wr_outstanding,
	output txn_count_t o_rd_outstanding,
	output logic       o_overflow
);

	// Handshake strobes, valid and ready at the same edge
	logic aw_hs;
	logic w_hs;
	logic b_hs;
	logic ar_hs;
	logic r_hs;

	// Up on request, down on response, hold if both
	function automatic txn_count_t step_count(input txn_count_t cnt, input logic up,
		input logic down);
		case ({up, down})
			2'b10:   return cnt + 1'b1;
			2'b01:   return cnt - 1'b1;
			default: return cnt;
		endcase
	endfunction

	assign aw_hs = i_axi_awvalid && i_axi_awready;
	assign w_hs  = i_axi_wvalid && i_axi_wready;
	assign b_hs  = i_axi_bvalid && i_axi_bready;
	assign ar_hs = i_axi_arvalid && i_axi_arready;
	assign r_hs  = i_axi_rvalid && i_axi_rready;

	////////////////////////////////////////////////////////////
	// Counters
	////////////////////////////////////////////////////////////
	always_ff @(posedge i_clk)
	begin
		if (!i_axi_reset_n)
		begin
			o_awr_outstanding <= '0;
			o_wr_outstanding  <= '0;
			o_rd_outstanding  <= '0;
		end
		else
		begin
			// A b response retires both write counts
			o_awr_outstanding <= step_count(o_awr_outstanding, aw_hs, b_hs);
			o_wr_outstanding  <= step_count(o_wr_outstanding, w_hs, b_hs);
			o_rd_outstanding  <= step_count(o_rd_outstanding, ar_hs, r_hs);
		end
	end

	// All ones means the next request would wrap
	assign o_overflow = (&o_awr_outstanding) || (&o_wr_outstanding)
		|| (&o_rd_outstanding);

endmodule

`default_nettype wire

//--- rtl/axil_wait_timer.sv
/*
 * AXI-lite stall and delay timers
 * Saturating timers for request stalls, response stalls and
 * request-to-response delay, each compared to its limit
 */
`timescale 1ns/1ps
`default_nettype none

`include "axil_monitor_params.svh"

module axil_wait_timer
	import axil_monitor_pkg::*;
(
	input  wire        i_clk,
	input  wire        i_axi_reset_n,
	input  wire        i_axi_awvalid,
	input  wire        i_axi_awready,
	input  wire        i_axi_wvalid,
	input  wire        i_axi_wready,
	input  wire        i_axi_bvalid,
	input  wire        i_axi_bready,
	input  wire        i_axi_arvalid,
	input  wire        i_axi_arready,
	input  wire        i_axi_rvalid,
	input  wire        i_axi_rready,
	input  wire txn_count_t i_awr_outstanding,
	input  wire txn_count_t i_wr_outstanding,
	input  wire txn_count_t i_rd_outstanding,
	output logic       o_req_stall,
	output logic       o_resp_stall,
	output logic       o_resp_delay
);

	localparam int TW = `AXIL_LGTIMEOUT;
	localparam logic [TW-1:0] WAIT_LIM   = TW'(`AXIL_MAX_WAIT);
	localparam logic [TW-1:0] RSTALL_LIM = TW'(`AXIL_MAX_RSTALL);
	localparam logic [TW-1:0] DELAY_LIM  = TW'(`AXIL_MAX_DELAY);

	// Run conditions, a timer clears whenever its condition drops
	logic aw_run;
	logic w_run;
	logic ar_run;
	logic b_run;
	logic r_run;
	logic wr_dly_run;
	logic rd_dly_run;

	logic [TW-1:0] aw_stall;
	logic [TW-1:0] w_stall;
	logic [TW-1:0] ar_stall;
	logic [TW-1:0] b_stall;
	logic [TW-1:0] r_stall;
	logic [TW-1:0] wr_delay;
	logic [TW-1:0] rd_delay;

	// Count up while running, stick at all ones
	function automatic logic [TW-1:0] next_timer(input logic [TW-1:0] t, input logic run);
		if (!run)
			return '0;
		else if (&t)
			return t;
		else
			return t + 1'b1;
	endfunction

	////////////////////////////////////////////////////////////
	// Request stalls
	////////////////////////////////////////////////////////////

	// Address waits on ready, unless a b response is pending
	// or the slave is just waiting for the matching data beat
	assign aw_run = i_axi_awvalid && !i_axi_awready && !i_axi_bvalid
		&& !(!i_axi_wvalid && (i_awr_outstanding >= i_wr_outstanding));

	// Same rule with the data channel leading
	assign w_run = i_axi_wvalid && !i_axi_wready && !i_axi_bvalid
		&& !(!i_axi_awvalid && (i_wr_outstanding >= i_awr_outstanding));

	// Read request stall, excused while a read response is up
	assign ar_run = i_axi_arvalid && !i_axi_arready && !i_axi_rvalid;

	////////////////////////////////////////////////////////////
	// Response stalls and delays
	////////////////////////////////////////////////////////////

	// Master holding off a response
	assign b_run = i_axi_bvalid && !i_axi_bready;
	assign r_run = i_axi_rvalid && !i_axi_rready;

	// Slave sitting on accepted requests with no response up
	assign wr_dly_run = (i_awr_outstanding != '0) && (i_wr_outstanding != '0)
		&& !i_axi_bvalid;
	assign rd_dly_run = (i_rd_outstanding != '0) && !i_axi_rvalid;

	always_ff @(posedge i_clk)
	begin
		if (!i_axi_reset_n)
		begin
			aw_stall <= '0;
			w_stall  <= '0;
			ar_stall <= '0;
			b_stall  <= '0;
			r_stall  <= '0;
			wr_delay <= '0;
			rd_delay <= '0;
		end
		else
		begin
			aw_stall <= next_timer(aw_stall, aw_run);
			w_stall  <= next_timer(w_stall, w_run);
			ar_stall <= next_timer(ar_stall, ar_run);
			b_stall  <= next_timer(b_stall, b_run);
			r_stall  <= next_timer(r_stall, r_run);
			wr_delay <= next_timer(wr_delay, wr_dly_run);
			rd_delay <= next_timer(rd_delay, rd_dly_run);
		end
	end

	// Level flags, high while a timer sits at its limit
	assign o_req_stall  = (aw_stall == WAIT_LIM) || (w_stall == WAIT_LIM)
		|| (ar_stall == WAIT_LIM);
	assign o_resp_stall = (b_stall == RSTALL_LIM) || (r_stall == RSTALL_LIM);
	assign o_resp_delay = (wr_delay == DELAY_LIM) || (rd_delay == DELAY_LIM);

endmodule

`default_nettype wire

//--- rtl/axil_channel_checker.sv
/*
 * AXI-lite response channel checker
 * Flags responses that change while stalled, EXOKAY codes and
 * responses that arrive with nothing outstanding
 */
`timescale 1ns/1ps
`default_nettype none

`include "axil_monitor_params.svh"

module axil_channel_checker
	import axil_monitor_pkg::*;
(
	input  wire                        i_clk,
	input  wire                        i_axi_reset_n,
	input  wire                        i_axi_bvalid,
	input  wire                        i_axi_bready,
	input  wire  [1:0]                 i_axi_bresp,
	input  wire                        i_axi_rvalid,
	input  wire                        i_axi_rready,
	input  wire  [`AXIL_DATA_WIDTH-1:0] i_axi_rdata,
	input  wire  [1:0]                 i_axi_rresp,
	input  wire txn_count_t            i_awr_outstanding,
	input  wire txn_count_t            i_wr_outstanding,
	input  wire txn_count_t            i_rd_outstanding,
	output logic                       o_b_unstable,
	output logic                       o_r_unstable,
	output logic                       o_exokay,
	output logic                       o_b_no_req,
	output logic                       o_r_no_req
);

	// Stall seen at the last edge
	logic b_stall_q;
	logic r_stall_q;

	// Response captured at the last edge
	axil_resp_e bresp_q;
	axil_resp_e rresp_q;
	logic [`AXIL_DATA_WIDTH-1:0] rdata_q;

	axil_resp_e bresp;
	axil_resp_e rresp;

	assign bresp = axil_resp_e'(i_axi_bresp);
	assign rresp = axil_resp_e'(i_axi_rresp);

	////////////////////////////////////////////////////////////
	// Previous cycle capture
	////////////////////////////////////////////////////////////
	always_ff @(posedge i_clk)
	begin
		if (!i_axi_reset_n)
		begin
			b_stall_q <= 1'b0;
			r_stall_q <= 1'b0;
		end
		else
		begin
			b_stall_q <= i_axi_bvalid && !i_axi_bready;
			r_stall_q <= i_axi_rvalid && !i_axi_rready;
		end
	end

	// Payload capture for the stability checks
	always_ff @(posedge i_clk)
	begin
		bresp_q <= bresp;
		rresp_q <= rresp;
		rdata_q <= i_axi_rdata;
	end

	////////////////////////////////////////////////////////////
	// Checks
	////////////////////////////////////////////////////////////

	// Held response must keep valid and its payload
	assign o_b_unstable = b_stall_q && (!i_axi_bvalid || (bresp != bresp_q));
	assign o_r_unstable = r_stall_q && (!i_axi_rvalid || (rresp != rresp_q)
		|| (i_axi_rdata != rdata_q));

	// Exclusive access is not supported on AXI-lite
	assign o_exokay = (i_axi_bvalid && (bresp == RESP_EXOKAY))
		|| (i_axi_rvalid && (rresp == RESP_EXOKAY));

	// Write response needs both address and data accepted
	assign o_b_no_req = i_axi_bvalid
		&& ((i_awr_outstanding == '0) || (i_wr_outstanding == '0));
	assign o_r_no_req = i_axi_rvalid && (i_rd_outstanding == '0);

endmodule

`default_nettype wire

//--- rtl/axil_monitor_fsm.sv
/*
 * AXI-lite monitor state machine
 * Reports idle or busy from the outstanding counts and latches
 * the highest priority fault until reset
 */
`timescale 1ns/1ps
`default_nettype none

module axil_monitor_fsm
	import axil_monitor_pkg::*;
(
	input  wire             i_clk,
	input  wire             i_axi_reset_n,
	input  wire txn_count_t i_awr_outstanding,
	input  wire txn_count_t i_wr_outstanding,
	input  wire txn_count_t i_rd_outstanding,
	input  wire             i_overflow,
	input  wire             i_b_no_req,
	input  wire             i_r_no_req,
	input  wire             i_b_unstable,
	input  wire             i_r_unstable,
	input  wire             i_exokay,
	input  wire             i_req_stall,
	input  wire             i_resp_stall,
	input  wire             i_resp_delay,
	output logic            o_busy,
	output logic            o_fault,
	output fault_code_e     o_fault_code
);

	mon_state_e  state;
	mon_state_e  state_next;
	fault_code_e code_now;
	logic        any_open;

	assign any_open = (i_awr_outstanding != '0) || (i_wr_outstanding != '0)
		|| (i_rd_outstanding != '0);

	// Priority encode the current violations
	always_comb
	begin
		if (i_overflow)
			code_now = FAULT_OVERFLOW;
		else if (i_b_no_req)
			code_now = FAULT_B_NO_REQ;
		else if (i_r_no_req)
			code_now = FAULT_R_NO_REQ;
		else if (i_b_unstable)
			code_now = FAULT_B_UNSTABLE;
		else if (i_r_unstable)
			code_now = FAULT_R_UNSTABLE;
		else if (i_exokay)
			code_now = FAULT_EXOKAY;
		else if (i_req_stall)
			code_now = FAULT_REQ_STALL;
		else if (i_resp_stall)
			code_now = FAULT_RESP_STALL;
		else if (i_resp_delay)
			code_now = FAULT_RESP_DELAY;
		else
			code_now = FAULT_NONE;
	end

	////////////////////////////////////////////////////////////
	// Next state
	////////////////////////////////////////////////////////////
	always_comb
	begin
		case (state)
			MON_FAULT: state_next = MON_FAULT;
			MON_IDLE, MON_BUSY:
			begin
				if (code_now != FAULT_NONE)
					state_next = MON_FAULT;
				else if (any_open)
					state_next = MON_BUSY;
				else
					state_next = MON_IDLE;
			end
			default: state_next = MON_IDLE;
		endcase
	end

	always_ff @(posedge i_clk)
	begin
		if (!i_axi_reset_n)
		begin
			state        <= MON_IDLE;
			o_fault_code <= FAULT_NONE;
		end
		else
		begin
			state <= state_next;
			// First fault wins, sticky until reset
			if ((state != MON_FAULT) && (code_now != FAULT_NONE))
				o_fault_code <= code_now;
		end
	end

	assign o_busy  = (state == MON_BUSY);
	assign o_fault = (state == MON_FAULT);

endmodule

`default_nettype wire

//--- rtl/axil_monitor.sv
/*
 * AXI-lite slave-side protocol monitor
 * Passive observer of an AXI-lite link, counts outstanding work,
 * times stalls and reports the first protocol fault
 */
`timescale 1ns/1ps
`default_nettype none

`include "axil_monitor_params.svh"

module axil_monitor
	import axil_monitor_pkg::*;
(
	input  wire                        i_clk,
	input  wire                        i_axi_reset_n,
	input  wire                        i_axi_awvalid,
	input  wire                        i_axi_awready,
	input  wire                        i_axi_wvalid,
	input  wire                        i_axi_wready,
	input  wire                        i_axi_bvalid,
	input  wire                        i_axi_bready,
	input  wire  [1:0]                 i_axi_bresp,
	input  wire                        i_axi_arvalid,
	input  wire                        i_axi_arready,
	input  wire                        i_axi_rvalid,
	input  wire                        i_axi_rready,
	input  wire  [`AXIL_DATA_WIDTH-1:0] i_axi_rdata,
	input  wire  [1:0]                 i_axi_rresp,
	output txn_count_t                 o_awr_outstanding,
	output txn_count_t                 o_wr_outstanding,
	output txn_count_t                 o_rd_outstanding,
	output logic                       o_busy,
	output logic                       o_fault,
	output fault_code_e                o_fault_code
);

	// Violation flags into the state machine
	logic overflow;
	logic req_stall;
	logic resp_stall;
	logic resp_delay;
	logic b_unstable;
	logic r_unstable;
	logic exokay;
	logic b_no_req;
	logic r_no_req;

	////////////////////////////////////////////////////////////
	// Transaction counting
	////////////////////////////////////////////////////////////
	axil_txn_counter u_counter (
		.i_clk             (i_clk),
		.i_axi_reset_n     (i_axi_reset_n),
		.i_axi_awvalid     (i_axi_awvalid),
		.i_axi_awready     (i_axi_awready),
		.i_axi_wvalid      (i_axi_wvalid),
		.i_axi_wready      (i_axi_wready),
		.i_axi_bvalid      (i_axi_bvalid),
		.i_axi_bready      (i_axi_bready),
		.i_axi_arvalid     (i_axi_arvalid),
		.i_axi_arready     (i_axi_arready),
		.i_axi_rvalid      (i_axi_rvalid),
		.i_axi_rready      (i_axi_rready),
		.o_awr_outstanding (o_awr_outstanding),
		.o_wr_outstanding  (o_wr_outstanding),
		.o_rd_outstanding  (o_rd_outstanding),
		.o_overflow        (overflow)
	);

	// Stall and delay timing
	axil_wait_timer u_timer (
		.i_clk             (i_clk),
		.i_axi_reset_n     (i_axi_reset_n),
		.i_axi_awvalid     (i_axi_awvalid),
		.i_axi_awready     (i_axi_awready),
		.i_axi_wvalid      (i_axi_wvalid),
		.i_axi_wready      (i_axi_wready),
		.i_axi_bvalid      (i_axi_bvalid),
		.i_axi_bready      (i_axi_bready),
		.i_axi_arvalid     (i_axi_arvalid),
		.i_axi_arready     (i_axi_arready),
		.i_axi_rvalid      (i_axi_rvalid),
		.i_axi_rready      (i_axi_rready),
		.i_awr_outstanding (o_awr_outstanding),
		.i_wr_outstanding  (o_wr_outstanding),
		.i_rd_outstanding  (o_rd_outstanding),
		.o_req_stall       (req_stall),
		.o_resp_stall      (resp_stall),
		.o_resp_delay      (resp_delay)
	);

	// Response channel rules
	axil_channel_checker u_checker (
		.i_clk             (i_clk),
		.i_axi_reset_n     (i_axi_reset_n),
		.i_axi_bvalid      (i_axi_bvalid),
		.i_axi_bready      (i_axi_bready),
		.i_axi_bresp       (i_axi_bresp),
		.i_axi_rvalid      (i_axi_rvalid),
		.i_axi_rready      (i_axi_rready),
		.i_axi_rdata       (i_axi_rdata),
		.i_axi_rresp       (i_axi_rresp),
		.i_awr_outstanding (o_awr_outstanding),
		.i_wr_outstanding  (o_wr_outstanding),
		.i_rd_outstanding  (o_rd_outstanding),
		.o_b_unstable      (b_unstable),
		.o_r_unstable      (r_unstable),
		.o_exokay          (exokay),
		.o_b_no_req        (b_no_req),
		.o_r_no_req        (r_no_req)
	);

	////////////////////////////////////////////////////////////
	// Status and fault latch
	////////////////////////////////////////////////////////////
	axil_monitor_fsm u_fsm (
		.i_clk             (i_clk),
		.i_axi_reset_n     (i_axi_reset_n),
		.i_awr_outstanding (o_awr_outstanding),
		.i_wr_outstanding  (o_wr_outstanding),
		.i_rd_outstanding  (o_rd_outstanding),
		.i_overflow        (overflow),
		.i_b_no_req        (b_no_req),
		.i_r_no_req        (r_no_req),
		.i_b_unstable      (b_unstable),
		.i_r_unstable      (r_unstable),
		.i_exokay          (exokay),
		.i_req_stall       (req_stall),
		.i_resp_stall      (resp_stall),
		.i_resp_delay      (resp_delay),
		.o_busy            (o_busy),
		.o_fault           (o_fault),
		.o_fault_code      (o_fault_code)
	);

endmodule

`default_nettype wire

//--- bench/tb_axil_monitor.sv
/*
 * AXI-lite monitor testbench
 * Runs clean random traffic and a set of protocol faults past the
 * monitor, checking the counts, busy and the latched fault code
 */
`timescale 1ns/1ps
`default_nettype none

`include "axil_monitor_params.svh"

module tb_axil_monitor
	import axil_monitor_pkg::*;
();

	// Six tests, each a reset plus 200 cycles
	localparam int WATCHDOG_NS = 6 * (10 + 200) * 10;

	logic                        i_clk;
	logic                        i_axi_reset_n;
	logic                        i_axi_awvalid;
	logic                        i_axi_awready;
	logic                        i_axi_wvalid;
	logic                        i_axi_wready;
	logic                        i_axi_bvalid;
	logic                        i_axi_bready;
	logic [1:0]                  i_axi_bresp;
	logic                        i_axi_arvalid;
	logic                        i_axi_arready;
	logic                        i_axi_rvalid;
	logic                        i_axi_rready;
	logic [`AXIL_DATA_WIDTH-1:0] i_axi_rdata;
	logic [1:0]                  i_axi_rresp;
	txn_count_t                  o_awr_outstanding;
	txn_count_t                  o_wr_outstanding;
	txn_count_t                  o_rd_outstanding;
	logic                        o_busy;
	logic                        o_fault;
	fault_code_e                 o_fault_code;

	// Reference counts, and busy as the FSM should show it
	txn_count_t model_awr;
	txn_count_t model_wr;
	txn_count_t model_rd;
	logic       busy_exp;
	logic       check_busy;
	int         seed;

	// Port names match the testbench signals one to one
	axil_monitor uut (.*);

	initial
	begin
		i_clk = 1'b0;
		forever #5 i_clk = ~i_clk;
	end

	// Watchdog
	initial
	begin
		#(WATCHDOG_NS);
		$display("error: watchdog expired before the tests finished");
		$display("*** FAILED ***");
		$fatal(1);
	end

	////////////////////////////////////////////////////////////
	// Helpers
	////////////////////////////////////////////////////////////

	task automatic check_value(input string name, input int expected, input int actual);
		assert (actual == expected)
		else
		begin
			$display("error at time %0t: %s expected %0d got %0d", $time, name,
				expected, actual);
			$display("*** FAILED ***");
			$fatal(1);
		end
	endtask

	// Request raises a count, response lowers it, both cancel
	function automatic txn_count_t next_count(input txn_count_t cnt, input logic req,
		input logic resp);
		if (req && !resp)
			return cnt + 1'b1;
		if (resp && !req)
			return cnt - 1'b1;
		return cnt;
	endfunction

	function automatic int rand_below(input int n);
		return int'({$random(seed)} % n);
	endfunction

	// Reference counter model, sampled at each rising edge
	always @(posedge i_clk)
	begin
		if (!i_axi_reset_n)
		begin
			model_awr <= '0;
			model_wr  <= '0;
			model_rd  <= '0;
			busy_exp  <= 1'b0;
		end
		else
		begin
			busy_exp  <= (model_awr != '0) || (model_wr != '0) || (model_rd != '0);
			model_awr <= next_count(model_awr, i_axi_awvalid && i_axi_awready,
				i_axi_bvalid && i_axi_bready);
			model_wr  <= next_count(model_wr, i_axi_wvalid && i_axi_wready,
				i_axi_bvalid && i_axi_bready);
			model_rd  <= next_count(model_rd, i_axi_arvalid && i_axi_arready,
				i_axi_rvalid && i_axi_rready);
		end
	end

	// Counts compared mid-cycle, busy only during clean traffic
	always @(negedge i_clk)
	begin
		if (i_axi_reset_n)
		begin
			check_value("o_awr_outstanding", int'(model_awr), int'(o_awr_outstanding));
			check_value("o_wr_outstanding", int'(model_wr), int'(o_wr_outstanding));
			check_value("o_rd_outstanding", int'(model_rd), int'(o_rd_outstanding));
			if (check_busy)
			begin
				check_value("o_busy", int'(busy_exp), int'(o_busy));
				check_value("o_fault", 0, int'(o_fault));
			end
		end
	end

	task automatic expect_quiet();
		@(negedge i_clk);
		check_value("o_fault", 0, int'(o_fault));
	endtask

	task automatic expect_latched(input fault_code_e code);
		@(negedge i_clk);
		check_value("o_fault", 1, int'(o_fault));
		check_value("o_fault_code", int'(code), int'(o_fault_code));
		check_value("o_busy", 0, int'(o_busy));
	endtask

	////////////////////////////////////////////////////////////
	// Bus drivers
	////////////////////////////////////////////////////////////

	task automatic idle_bus();
		i_axi_awvalid <= 1'b0;
		i_axi_awready <= 1'b0;
		i_axi_wvalid  <= 1'b0;
		i_axi_wready  <= 1'b0;
		i_axi_bvalid  <= 1'b0;
		i_axi_bready  <= 1'b0;
		i_axi_bresp   <= RESP_OKAY;
		i_axi_arvalid <= 1'b0;
		i_axi_arready <= 1'b0;
		i_axi_rvalid  <= 1'b0;
		i_axi_rready  <= 1'b0;
		i_axi_rdata   <= '0;
		i_axi_rresp   <= RESP_OKAY;
	endtask

	task automatic apply_reset();
		@(posedge i_clk);
		i_axi_reset_n <= 1'b0;
		idle_bus();
		repeat (10) @(posedge i_clk);
		i_axi_reset_n <= 1'b1;
	endtask

	// Ready follows valid after dly cycles, one beat each
	task automatic drive_aw(input int dly);
		@(posedge i_clk);
		i_axi_awvalid <= 1'b1;
		i_axi_awready <= 1'b0;
		repeat (dly) @(posedge i_clk);
		i_axi_awready <= 1'b1;
		@(posedge i_clk);
		i_axi_awvalid <= 1'b0;
		i_axi_awready <= 1'b0;
	endtask

	task automatic drive_w(input int dly);
		@(posedge i_clk);
		i_axi_wvalid <= 1'b1;
		i_axi_wready <= 1'b0;
		repeat (dly) @(posedge i_clk);
		i_axi_wready <= 1'b1;
		@(posedge i_clk);
		i_axi_wvalid <= 1'b0;
		i_axi_wready <= 1'b0;
	endtask

	task automatic drive_ar(input int dly);
		@(posedge i_clk);
		i_axi_arvalid <= 1'b1;
		i_axi_arready <= 1'b0;
		repeat (dly) @(posedge i_clk);
		i_axi_arready <= 1'b1;
		@(posedge i_clk);
		i_axi_arvalid <= 1'b0;
		i_axi_arready <= 1'b0;
	endtask

	// Address and data channels run side by side
	task automatic issue_write(input int aw_dly, input int w_dly);
		fork
			drive_aw(aw_dly);
			drive_w(w_dly);
		join
	endtask

	// Slave response after a random gap, master ready after another
	task automatic return_response(input logic is_read);
		int         wait_cycles;
		int         hold_cycles;
		logic [1:0] resp;
		wait_cycles = rand_below(5);
		hold_cycles = rand_below(5);
		resp = (rand_below(2) == 0) ? RESP_OKAY : RESP_SLVERR;
		repeat (wait_cycles + 1) @(posedge i_clk);
		if (is_read)
		begin
			i_axi_rvalid <= 1'b1;
			i_axi_rready <= 1'b0;
			i_axi_rresp  <= resp;
			i_axi_rdata  <= $random(seed);
		end
		else
		begin
			i_axi_bvalid <= 1'b1;
			i_axi_bready <= 1'b0;
			i_axi_bresp  <= resp;
		end
		repeat (hold_cycles) @(posedge i_clk);
		if (is_read)
			i_axi_rready <= 1'b1;
		else
			i_axi_bready <= 1'b1;
		@(posedge i_clk);
		i_axi_rvalid <= 1'b0;
		i_axi_rready <= 1'b0;
		i_axi_bvalid <= 1'b0;
		i_axi_bready <= 1'b0;
	endtask

	// Groups of up to three requests, then their responses
	task automatic run_clean_traffic();
		int   done;
		int   group;
		int   aw_dly;
		int   w_dly;
		logic is_read;
		done = 0;
		while (done < 40)
		begin
			group   = 1 + rand_below(3);
			is_read = (rand_below(2) == 0);
			repeat (group)
			begin
				aw_dly = rand_below(5);
				w_dly  = rand_below(5);
				if (is_read)
					drive_ar(aw_dly);
				else
					issue_write(aw_dly, w_dly);
			end
			repeat (group)
				return_response(is_read);
			done += group;
		end
	endtask

	////////////////////////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////////////////////////
	initial
	begin
		seed          = 5;
		check_busy    = 1'b0;
		i_axi_reset_n <= 1'b0;
		idle_bus();

		$display("test 1: clean traffic");
		apply_reset();
		check_busy = 1'b1;
		run_clean_traffic();
		repeat (2) @(posedge i_clk);
		check_busy = 1'b0;

		$display("test 2: EXOKAY read response");
		apply_reset();
		drive_ar(0);
		@(posedge i_clk);
		i_axi_rvalid <= 1'b1;
		i_axi_rready <= 1'b1;
		i_axi_rresp  <= RESP_EXOKAY;
		expect_quiet();
		@(posedge i_clk);
		idle_bus();
		expect_latched(FAULT_EXOKAY);
		// Sticky until the next reset
		repeat (20) expect_latched(FAULT_EXOKAY);

		$display("test 3: unstable responses");
		apply_reset();
		drive_ar(0);
		@(posedge i_clk);
		i_axi_rvalid <= 1'b1;
		i_axi_rdata  <= 32'hA5A5_0001;
		expect_quiet();
		@(posedge i_clk);
		i_axi_rdata <= 32'hA5A5_0002;
		expect_quiet();
		expect_latched(FAULT_R_UNSTABLE);
		apply_reset();
		issue_write(0, 0);
		@(posedge i_clk);
		i_axi_bvalid <= 1'b1;
		expect_quiet();
		// bvalid drops while bready never came
		@(posedge i_clk);
		i_axi_bvalid <= 1'b0;
		expect_quiet();
		expect_latched(FAULT_B_UNSTABLE);

		$display("test 4: responses without a request");
		apply_reset();
		@(posedge i_clk);
		i_axi_bvalid <= 1'b1;
		expect_quiet();
		expect_latched(FAULT_B_NO_REQ);
		apply_reset();
		@(posedge i_clk);
		i_axi_rvalid <= 1'b1;
		expect_quiet();
		expect_latched(FAULT_R_NO_REQ);

		$display("test 5: timeouts");
		apply_reset();
		@(posedge i_clk);
		i_axi_arvalid <= 1'b1;
		repeat (`AXIL_MAX_WAIT + 1) expect_quiet();
		expect_latched(FAULT_REQ_STALL);
		apply_reset();
		drive_ar(0);
		@(posedge i_clk);
		i_axi_rvalid <= 1'b1;
		repeat (`AXIL_MAX_RSTALL + 1) expect_quiet();
		expect_latched(FAULT_RESP_STALL);
		apply_reset();
		drive_ar(0);
		repeat (`AXIL_MAX_DELAY + 1) expect_quiet();
		expect_latched(FAULT_RESP_DELAY);

		$display("test 6: counter overflow");
		apply_reset();
		@(posedge i_clk);
		i_axi_awvalid <= 1'b1;
		i_axi_awready <= 1'b1;
		i_axi_wvalid  <= 1'b1;
		i_axi_wready  <= 1'b1;
		repeat (15) expect_quiet();
		@(posedge i_clk);
		idle_bus();
		// Counts sit at all ones here, latch comes next edge
		expect_quiet();
		expect_latched(FAULT_OVERFLOW);

		$display("*** PASSED ***");
		$finish;
	end

endmodule

`default_nettype wire

//--- axil_monitor.f
+incdir+rtl
rtl/axil_monitor_pkg.sv
rtl/axil_txn_counter.sv
rtl/axil_wait_timer.sv
rtl/axil_channel_checker.sv
rtl/axil_monitor_fsm.sv
rtl/axil_monitor.sv
bench/tb_axil_monitor.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the AXI-lite monitor testbench with Verilator
# A failing build or a failing simulation gives a nonzero exit status

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps -f axil_monitor.f \
	--top-module tb_axil_monitor -Mdir obj_dir -o tb_axil_monitor
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit $status
fi

./obj_dir/tb_axil_monitor
status=$?
if [ $status -ne 0 ]; then
	echo "Simulation failed with status $status"
	exit $status
fi

exit 0
